//--- compile.f
hw/decodePkg.sv
hw/opDecoder.sv
hw/immGen.sv
hw/decodeRecord.sv
hw/decodeUnit.sv
verification/decodeUnit_asserts.sv
verification/decodeUnitTb.sv

//--- verification/decodeUnitTb.sv
/* Table-driven testbench for the decode stage. Words are encoded from their fields,
   applied one per cycle, and each record is checked one cycle after it was applied. */
module decodeUnitTb;
    import decodePkg::*;

    localparam int resetCycles = 4;

    logic        clk;
    logic        reset;
    logic        decEn;
    addrT        instPc;
    instT        inst;
    decodedInstT decoded;

    // stimulus table, one entry per cycle.
    string       names[$];
    logic        enQ[$];
    instT        instQ[$];
    addrT        pcQ[$];
    decodedInstT expQ[$];

    int cycleCount = 0;
    int cycleLimit = 0;

    decodeUnit i_dut (
        .clk     (clk),
        .reset   (reset),
        .decEn   (decEn),
        .instPc  (instPc),
        .inst    (inst),
        .decoded (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the table did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic regNameT randName();
        return regNameT'(1 + ($urandom % 31)); // never x0.
    endfunction

    function automatic decodedInstT expRec(input opClassT cls, input opCodeT op,
            input regNameT r1, input regNameT r2, input regNameT rd,
            input addrT pc, input dataT imm, input logic ill);
        decodedInstT rec;
        rec.valid   = 1'b1;
        rec.illegal = ill;
        rec.opClass = cls;
        rec.opCode  = op;
        rec.rs1     = r1;
        rec.rs2     = r2;
        rec.rd      = rd;
        rec.pc      = pc;
        rec.imm     = imm;
        return rec;
    endfunction

    function automatic decodedInstT idleRec();
        decodedInstT rec;
        rec = expRec(classNop, opNop, nameFree, nameFree, nameFree, '0, '0, 1'b0);
        rec.valid = 1'b0;
        return rec;
    endfunction

    task automatic pushEntry(input string name, input logic en, input instT word,
            input addrT pc, input decodedInstT exp);
        names.push_back(name);
        enQ.push_back(en);
        instQ.push_back(word);
        pcQ.push_back(pc);
        expQ.push_back(exp);
    endtask

    task automatic addRegReg(input string name, input logic [6:0] f7, input logic [2:0] f3,
            input opCodeT op);
        regNameT a, b, d;
        addrT pc;
        a = randName();
        b = randName();
        d = randName();
        pc = $urandom;
        pushEntry(name, 1'b1, {f7, b, a, f3, d, classRegReg}, pc,
            expRec(classRegReg, op, a, b, d, pc, '0, 1'b0));
    endtask

    // I format, used by jalr, loads and register-immediate ops.
    task automatic addImm(input string name, input opClassT cls, input logic [2:0] f3,
            input int imm, input opCodeT op);
        regNameT a, d;
        addrT pc;
        dataT v;
        a = randName();
        d = randName();
        pc = $urandom;
        v = imm;
        pushEntry(name, 1'b1, {v[11:0], a, f3, d, cls}, pc,
            expRec(cls, op, a, nameFree, d, pc, v, 1'b0));
    endtask

    task automatic addStore(input string name, input logic [2:0] f3, input int imm,
            input opCodeT op);
        regNameT a, b;
        addrT pc;
        dataT v;
        a = randName();
        b = randName();
        pc = $urandom;
        v = imm;
        pushEntry(name, 1'b1, {v[11:5], b, a, f3, v[4:0], classStore}, pc,
            expRec(classStore, op, a, b, nameFree, pc, v, 1'b0));
    endtask

    task automatic addBranch(input string name, input logic [2:0] f3, input int imm,
            input opCodeT op);
        regNameT a, b;
        addrT pc;
        dataT v;
        a = randName();
        b = randName();
        pc = $urandom;
        v = imm;
        pushEntry(name, 1'b1, {v[12], v[10:5], b, a, f3, v[4:1], v[11], classBranch}, pc,
            expRec(classBranch, op, a, b, nameFree, pc, v, 1'b0));
    endtask

    task automatic addUpper(input string name, input opClassT cls, input dataT v,
            input opCodeT op);
        regNameT d;
        addrT pc;
        d = randName();
        pc = $urandom;
        pushEntry(name, 1'b1, {v[31:12], d, cls}, pc,
            expRec(cls, op, nameFree, nameFree, d, pc, {v[31:12], 12'b0}, 1'b0));
    endtask

    task automatic addJal(input string name, input int imm);
        regNameT d;
        addrT pc;
        dataT v;
        d = randName();
        pc = $urandom;
        v = imm;
        pushEntry(name, 1'b1, {v[20], v[10:1], v[11], v[19:12], d, classJal}, pc,
            expRec(classJal, opJal, nameFree, nameFree, d, pc, v, 1'b0));
    endtask

    task automatic addIllegal(input string name, input logic [6:0] f7, input logic [2:0] f3,
            input logic [6:0] opc, input opClassT cls);
        addrT pc;
        pc = $urandom;
        pushEntry(name, 1'b1, {f7, randName(), randName(), f3, randName(), opc}, pc,
            expRec(cls, opNop, nameFree, nameFree, nameFree, pc, '0, 1'b1));
    endtask

    task automatic addIdle(input string name);
        pushEntry(name, 1'b0, $urandom, $urandom, idleRec()); // junk word must be ignored.
    endtask

    task automatic buildTable();
        addIdle("idle first");
        addUpper("lui neg", classLui, 32'hfffe_1000, opLui);
        addUpper("auipc pos", classAuipc, 32'h1234_5000, opAuipc);
        addJal("jal neg", -2048);
        addJal("jal pos", 1044);
        addImm("jalr neg", classJalr, funct3Jalr, -4, opJalr);
        addImm("jalr pos", classJalr, funct3Jalr, 300, opJalr);
        addBranch("beq neg", funct3Beq, -16, opBeq);
        addBranch("bne pos", funct3Bne, 2050, opBne);
        addBranch("blt", funct3Blt, -4096, opBlt);
        addBranch("bge", funct3Bge, 8, opBge);
        addBranch("bltu", funct3Bltu, 4094, opBltu);
        addBranch("bgeu", funct3Bgeu, -2, opBgeu);
        addImm("lb", classLoad, funct3Byte, -1, opLb);
        addImm("lh", classLoad, funct3Half, 2047, opLh);
        addImm("lw", classLoad, funct3Word, -2048, opLw);
        addImm("lbu", classLoad, funct3ByteU, 12, opLbu);
        addImm("lhu", classLoad, funct3HalfU, -100, opLhu);
        addStore("sb neg", funct3Byte, -33, opSb);
        addStore("sh pos", funct3Half, 1000, opSh);
        addStore("sw", funct3Word, -2048, opSw);
        addIdle("idle mid");
        addImm("addi", classRegImm, funct3AddSub, -7, opAdd);
        addImm("slli", classRegImm, funct3Sll, {funct7Base, 5'd5}, opSll);
        addImm("slti", classRegImm, funct3Slt, 100, opSlt);
        addImm("sltiu", classRegImm, funct3Sltu, -1, opSltu);
        addImm("xori", classRegImm, funct3Xor, 1365, opXor);
        addImm("srli", classRegImm, funct3SrlSra, {funct7Base, 5'd31}, opSrl);
        addImm("srai", classRegImm, funct3SrlSra, {funct7Alt, 5'd3}, opSra);
        addImm("ori", classRegImm, funct3Or, -256, opOr);
        addImm("andi", classRegImm, funct3And, 255, opAnd);
        addRegReg("add", funct7Base, funct3AddSub, opAdd);
        addRegReg("sub", funct7Alt, funct3AddSub, opSub);
        addRegReg("sll", funct7Base, funct3Sll, opSll);
        addRegReg("slt", funct7Base, funct3Slt, opSlt);
        addRegReg("sltu", funct7Base, funct3Sltu, opSltu);
        addRegReg("xor", funct7Base, funct3Xor, opXor);
        addRegReg("srl", funct7Base, funct3SrlSra, opSrl);
        addRegReg("sra", funct7Alt, funct3SrlSra, opSra);
        addIdle("idle gap");
        addRegReg("or", funct7Base, funct3Or, opOr);
        addRegReg("and", funct7Base, funct3And, opAnd);
        addIllegal("unknown opcode", funct7Base, 3'b000, 7'b1111111, classNop);
        addIllegal("branch funct3 011", funct7Base, 3'b011, classBranch, classBranch);
        addIllegal("regreg funct7 0000001", 7'b0000001, funct3AddSub, classRegReg, classRegReg);
        addIdle("idle last");
    endtask

    task automatic failCheck(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "decoded record mismatch");
    endtask

    task automatic checkClass(input string name, input opClassT exp, input opClassT act);
        if (act !== exp)
            failCheck($sformatf("[FAIL] %s: expected %s, actual %s", name, exp.name(),
                act.name()));
    endtask

    task automatic checkOp(input string name, input opCodeT exp, input opCodeT act);
        if (act !== exp)
            failCheck($sformatf("[FAIL] %s: expected %s, actual %s", name, exp.name(),
                act.name()));
    endtask

    task automatic checkName(input string name, input regNameT exp, input regNameT act);
        if (act !== exp)
            failCheck($sformatf("[FAIL] %s: expected x%0d, actual x%0d", name, exp, act));
    endtask

    task automatic checkData(input string name, input dataT exp, input dataT act);
        if (act !== exp)
            failCheck($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp)
            failCheck($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic checkRecord(input string name, input decodedInstT exp);
        checkFlag({name, " valid"}, exp.valid, decoded.valid);
        checkFlag({name, " illegal"}, exp.illegal, decoded.illegal);
        checkClass({name, " class"}, exp.opClass, decoded.opClass);
        checkOp({name, " op"}, exp.opCode, decoded.opCode);
        checkName({name, " rs1"}, exp.rs1, decoded.rs1);
        checkName({name, " rs2"}, exp.rs2, decoded.rs2);
        checkName({name, " rd"}, exp.rd, decoded.rd);
        checkData({name, " pc"}, exp.pc, decoded.pc);
        checkData({name, " imm"}, exp.imm, decoded.imm);
    endtask

    task automatic driveEntry(input int idx);
        decEn  = enQ[idx];
        instPc = pcQ[idx];
        inst   = instQ[idx];
    endtask

    initial begin
        reset  = 1'b1;
        decEn  = 1'b0;
        instPc = '0;
        inst   = '0;
        void'($urandom(32'hacab3d70));
        buildTable();
        cycleLimit = resetCycles + names.size() + 20;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkRecord("reset", idleRec());
        end
        reset = 1'b0;
        driveEntry(0);
        // entry i-1 is checked while entry i is applied.
        for (int i = 1; i <= names.size(); i++) begin
            @(posedge clk);
            #1;
            checkRecord(names[i-1], expQ[i-1]);
            if (i < names.size()) begin
                driveEntry(i);
            end else begin
                decEn  = 1'b0;
                instPc = '0;
                inst   = '0;
            end
        end
        if (i_dut.i_decodeRecord.i_asserts.assertFails != 0) begin
            $display("bound assertions on the decoded record failed %0d times",
                i_dut.i_decodeRecord.i_asserts.assertFails);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failures");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- verification/decodeUnit_asserts.sv
/* Concurrent checks on the registered decode record, bound into decodeRecord.
   Covers the illegal, idle and reset rules of the record. */
module decodeUnit_asserts (
    input logic                   clk,
    input logic                   reset,
    input decodePkg::decodedInstT decoded
);
    import decodePkg::*;

    int assertFails = 0;

    illegalIsNop: assert property (@(posedge clk) decoded.illegal |-> decoded.opCode == opNop)
        else begin
            $error("illegal record carries an operation other than nop");
            assertFails++;
        end

    // bubbles carry no names and no immediate.
    idleIsClean: assert property (@(posedge clk) !decoded.valid |->
        (decoded.rs1 == nameFree && decoded.rs2 == nameFree &&
         decoded.rd == nameFree && decoded.imm == '0))
        else begin
            $error("record with valid low has a register name or immediate set");
            assertFails++;
        end

    resetClears: assert property (@(posedge clk) reset |=> !decoded.valid)
        else begin
            $error("valid still high one edge after reset");
            assertFails++;
        end

endmodule

bind decodeRecord decodeUnit_asserts i_asserts (
    .clk     (clk),
    .reset   (reset),
    .decoded (decoded)
);

//--- hw/decodeUnit.sv
/* Top of the decode stage: opcode decoder and immediate generator
   in parallel, feeding the registered record builder. */
module decodeUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   decEn,
    input  decodePkg::addrT        instPc,
    input  decodePkg::instT        inst,
    output decodePkg::decodedInstT decoded
);
    import decodePkg::*;

    opDecodeT opDec;
    immSetT   immSet;

    opDecoder i_opDecoder (
        .inst  (inst),
        .opDec (opDec)
    );

    immGen i_immGen (
        .inst   (inst),
        .immSet (immSet)
    );

    decodeRecord i_decodeRecord (
        .clk     (clk),
        .reset   (reset),
        .decEn   (decEn),
        .instPc  (instPc),
        .inst    (inst),
        .opDec   (opDec),
        .immSet  (immSet),
        .decoded (decoded)
    );

endmodule

//--- hw/decodeRecord.sv
/* Record builder and output register of the decode stage.
   Selects the immediate, frees unused register names, registers the record. */
module decodeRecord (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   decEn,
    input  decodePkg::addrT        instPc,
    input  decodePkg::instT        inst,
    input  decodePkg::opDecodeT    opDec,
    input  decodePkg::immSetT      immSet,
    output decodePkg::decodedInstT decoded
);
    import decodePkg::*;

    logic useRs1;
    logic useRs2;
    logic useRd;
    dataT immSel;
    decodedInstT nextRec;

    always_comb begin
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        useRd  = 1'b0;
        immSel = '0;
        case (opDec.opClass)
            classLui, classAuipc: begin
                immSel = immSet.immU;
                useRd  = 1'b1;
            end
            classJal: begin
                immSel = immSet.immJ;
                useRd  = 1'b1;
            end
            classJalr, classLoad, classRegImm: begin
                immSel = immSet.immI;
                useRs1 = 1'b1;
                useRd  = 1'b1;
            end
            classBranch: begin
                immSel = immSet.immB;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
            end
            classStore: begin
                immSel = immSet.immS;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
            end
            classRegReg: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                useRd  = 1'b1;
            end
            default: ;
        endcase
        if (opDec.illegal) begin
            useRs1 = 1'b0;
            useRs2 = 1'b0;
            useRd  = 1'b0;
            immSel = '0;
        end
    end

    always_comb begin
        nextRec.valid   = 1'b1;
        nextRec.illegal = opDec.illegal;
        nextRec.opClass = opDec.opClass;
        nextRec.opCode  = opDec.opCode;
        nextRec.rs1     = useRs1 ? inst[rs1Lsb +: nameWidth] : nameFree;
        nextRec.rs2     = useRs2 ? inst[rs2Lsb +: nameWidth] : nameFree;
        nextRec.rd      = useRd ? inst[rdLsb +: nameWidth] : nameFree;
        nextRec.pc      = instPc;
        nextRec.imm     = immSel;
    end

    always_ff @(posedge clk) begin
        if (reset || !decEn) decoded <= decodedIdle; // idle bubble.
        else decoded <= nextRec;
    end

endmodule

//--- hw/immGen.sv
/* Builds every RV32I immediate format from one instruction word.
   The record builder picks the one that matches the class. */
module immGen (
    input  decodePkg::instT   inst,
    output decodePkg::immSetT immSet
);
    import decodePkg::*;

    // sign fill widths per format.
    localparam int fillI = dataWidth - 12;
    localparam int fillB = dataWidth - 13;
    localparam int fillJ = dataWidth - 21;

    dataT immI;
    dataT immS;
    dataT immB;
    dataT immU;
    dataT immJ;

    assign immI = {{fillI{inst[31]}}, inst[31:20]};
    assign immS = {{fillI{inst[31]}}, inst[31:25], inst[11:7]};

    // branch offset, bit 0 always zero.
    assign immB = {
        {fillB{inst[31]}},
        inst[31],
        inst[7],
        inst[30:25],
        inst[11:8],
        1'b0
    };

    assign immU = {inst[31:12], 12'b0};

    assign immJ = {
        {fillJ{inst[31]}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign immSet.immI = immI;
    assign immSet.immS = immS;
    assign immSet.immB = immB;
    assign immSet.immU = immU;
    assign immSet.immJ = immJ;

endmodule

//--- hw/opDecoder.sv
/* Combinational opcode decoder.
   Maps opcode, funct3 and funct7 to class, operation and an illegal flag. */
module opDecoder (
    input  decodePkg::instT     inst,
    output decodePkg::opDecodeT opDec
);
    import decodePkg::*;

    logic [opcodeWidth-1:0] opcode;
    logic [funct3Width-1:0] funct3;
    logic [funct7Width-1:0] funct7;

    assign opcode = inst[opcodeLsb +: opcodeWidth];
    assign funct3 = inst[funct3Lsb +: funct3Width];
    assign funct7 = inst[funct7Lsb +: funct7Width];

    always_comb begin
        opDec.opClass = classNop;
        opDec.opCode  = opNop;
        opDec.illegal = 1'b0;
        case (opcode)
            classLui: begin
                opDec.opClass = classLui;
                opDec.opCode  = opLui;
            end
            classAuipc: begin
                opDec.opClass = classAuipc;
                opDec.opCode  = opAuipc;
            end
            classJal: begin
                opDec.opClass = classJal;
                opDec.opCode  = opJal;
            end
            classJalr: begin
                opDec.opClass = classJalr;
                if (funct3 == funct3Jalr) opDec.opCode = opJalr;
                else opDec.illegal = 1'b1;
            end
            classBranch: begin
                opDec.opClass = classBranch;
                case (funct3)
                    funct3Beq:  opDec.opCode = opBeq;
                    funct3Bne:  opDec.opCode = opBne;
                    funct3Blt:  opDec.opCode = opBlt;
                    funct3Bge:  opDec.opCode = opBge;
                    funct3Bltu: opDec.opCode = opBltu;
                    funct3Bgeu: opDec.opCode = opBgeu;
                    default:    opDec.illegal = 1'b1;
                endcase
            end
            classLoad: begin
                opDec.opClass = classLoad;
                case (funct3)
                    funct3Byte:  opDec.opCode = opLb;
                    funct3Half:  opDec.opCode = opLh;
                    funct3Word:  opDec.opCode = opLw;
                    funct3ByteU: opDec.opCode = opLbu;
                    funct3HalfU: opDec.opCode = opLhu;
                    default:     opDec.illegal = 1'b1;
                endcase
            end
            classStore: begin
                opDec.opClass = classStore;
                case (funct3)
                    funct3Byte: opDec.opCode = opSb;
                    funct3Half: opDec.opCode = opSh;
                    funct3Word: opDec.opCode = opSw;
                    default:    opDec.illegal = 1'b1;
                endcase
            end
            classRegImm: begin
                opDec.opClass = classRegImm;
                case (funct3)
                    funct3AddSub: opDec.opCode = opAdd; // addi only.
                    funct3Sll: begin
                        if (funct7 == funct7Base) opDec.opCode = opSll;
                        else opDec.illegal = 1'b1;
                    end
                    funct3Slt:  opDec.opCode = opSlt;
                    funct3Sltu: opDec.opCode = opSltu;
                    funct3Xor:  opDec.opCode = opXor;
                    funct3SrlSra: begin
                        if (funct7 == funct7Base) opDec.opCode = opSrl;
                        else if (funct7 == funct7Alt) opDec.opCode = opSra;
                        else opDec.illegal = 1'b1;
                    end
                    funct3Or:  opDec.opCode = opOr;
                    default:   opDec.opCode = opAnd; // funct3And.
                endcase
            end
            classRegReg: begin
                opDec.opClass = classRegReg;
                case (funct3)
                    funct3AddSub: begin
                        if (funct7 == funct7Base) opDec.opCode = opAdd;
                        else if (funct7 == funct7Alt) opDec.opCode = opSub;
                        else opDec.illegal = 1'b1;
                    end
                    funct3Sll: begin
                        if (funct7 == funct7Base) opDec.opCode = opSll;
                        else opDec.illegal = 1'b1;
                    end
                    funct3Slt:  opDec.opCode = opSlt;
                    funct3Sltu: opDec.opCode = opSltu;
                    funct3Xor:  opDec.opCode = opXor;
                    funct3SrlSra: begin
                        if (funct7 == funct7Base) opDec.opCode = opSrl;
                        else if (funct7 == funct7Alt) opDec.opCode = opSra;
                        else opDec.illegal = 1'b1;
                    end
                    funct3Or:  opDec.opCode = opOr;
                    default:   opDec.opCode = opAnd; // funct3And.
                endcase
            end
            default: opDec.illegal = 1'b1; // unknown opcode.
        endcase
    end

endmodule

//--- hw/decodePkg.sv
/* Shared types and constants for the RV32I decode stage.
   Imported by every decode module and by the testbench for encoding words. */
package decodePkg;

    localparam int instWidth = 32;
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int nameWidth = 5;

    // instruction field positions.
    localparam int opcodeLsb   = 0;
    localparam int opcodeWidth = 7;
    localparam int rdLsb       = 7;
    localparam int funct3Lsb   = 12;
    localparam int funct3Width = 3;
    localparam int rs1Lsb      = 15;
    localparam int rs2Lsb      = 20;
    localparam int funct7Lsb   = 25;
    localparam int funct7Width = 7;

    typedef logic [instWidth-1:0] instT;
    typedef logic [addrWidth-1:0] addrT;
    typedef logic [dataWidth-1:0] dataT;
    typedef logic [nameWidth-1:0] regNameT;

    localparam regNameT nameFree = '0; // x0.

    // class value is the raw major opcode.
    typedef enum logic [opcodeWidth-1:0] {
        classNop    = 7'b0000000,
        classLoad   = 7'b0000011,
        classRegImm = 7'b0010011,
        classAuipc  = 7'b0010111,
        classStore  = 7'b0100011,
        classRegReg = 7'b0110011,
        classLui    = 7'b0110111,
        classBranch = 7'b1100011,
        classJalr   = 7'b1100111,
        classJal    = 7'b1101111
    } opClassT;

    typedef enum logic [5:0] {
        opNop, opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd
    } opCodeT;

    localparam logic [funct3Width-1:0] funct3Jalr   = 3'b000;
    localparam logic [funct3Width-1:0] funct3Beq    = 3'b000;
    localparam logic [funct3Width-1:0] funct3Bne    = 3'b001;
    localparam logic [funct3Width-1:0] funct3Blt    = 3'b100;
    localparam logic [funct3Width-1:0] funct3Bge    = 3'b101;
    localparam logic [funct3Width-1:0] funct3Bltu   = 3'b110;
    localparam logic [funct3Width-1:0] funct3Bgeu   = 3'b111;
    localparam logic [funct3Width-1:0] funct3Byte   = 3'b000; // lb, sb.
    localparam logic [funct3Width-1:0] funct3Half   = 3'b001; // lh, sh.
    localparam logic [funct3Width-1:0] funct3Word   = 3'b010; // lw, sw.
    localparam logic [funct3Width-1:0] funct3ByteU  = 3'b100;
    localparam logic [funct3Width-1:0] funct3HalfU  = 3'b101;
    localparam logic [funct3Width-1:0] funct3AddSub = 3'b000;
    localparam logic [funct3Width-1:0] funct3Sll    = 3'b001;
    localparam logic [funct3Width-1:0] funct3Slt    = 3'b010;
    localparam logic [funct3Width-1:0] funct3Sltu   = 3'b011;
    localparam logic [funct3Width-1:0] funct3Xor    = 3'b100;
    localparam logic [funct3Width-1:0] funct3SrlSra = 3'b101;
    localparam logic [funct3Width-1:0] funct3Or     = 3'b110;
    localparam logic [funct3Width-1:0] funct3And    = 3'b111;

    localparam logic [funct7Width-1:0] funct7Base = 7'b0000000;
    localparam logic [funct7Width-1:0] funct7Alt  = 7'b0100000; // sub, sra.

    typedef struct packed {
        opClassT opClass;
        opCodeT  opCode;
        logic    illegal;
    } opDecodeT;

    typedef struct packed {
        dataT immI;
        dataT immS;
        dataT immB;
        dataT immU;
        dataT immJ;
    } immSetT;

    typedef struct packed {
        logic    valid;
        logic    illegal;
        opClassT opClass;
        opCodeT  opCode;
        regNameT rs1;
        regNameT rs2;
        regNameT rd;
        addrT    pc;
        dataT    imm;
    } decodedInstT;

    localparam decodedInstT decodedIdle = '{
        valid: 1'b0, illegal: 1'b0, opClass: classNop, opCode: opNop,
        rs1: nameFree, rs2: nameFree, rd: nameFree, pc: '0, imm: '0
    };

endpackage
